//--- verilog/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    // Data, virtual and physical address widths
    localparam int XLEN  = 32;
    localparam int VALEN = 32;
    localparam int PALEN = 32;

    // Entries in each TLB, kept a power of two for the fill pointer
    localparam int TLB_ENTRIES = 4;

    typedef enum logic [1:0] {
        IDLE,
        PROCESS_PTE,
        PAGE_ERR,
        WAIT_R_VALID
    } ptw_state_e;

    typedef enum logic {
        LEVEL_1,
        LEVEL_2
    } ptw_level_e;

    // Sv32 flag byte, V sits in bit 0
    typedef struct packed {
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_flags_s;

    // One PTE word seen either as a leaf or as a pointer to the next table
    typedef union packed {
        struct packed {
            logic [11:0] ppn1;
            logic [9:0]  ppn0;
            logic [1:0]  rsw;
            pte_flags_s  flags;
        } leaf_view;
        struct packed {
            logic [21:0] ppn;
            logic [1:0]  rsw;
            pte_flags_s  flags;
        } table_view;
    } pte_u;

    typedef struct packed {
        logic        valid;
        logic [19:0] vpn;
        logic [21:0] ppn;
        logic        page_4m;
        pte_flags_s  flags;
    } tlb_entry_s;

endpackage

`default_nettype wire

//--- verilog/tlb.sv
`default_nettype none

interface tlb_fill_if;
    logic                itlb_update;
    logic                dtlb_update;
    mmu_pkg::tlb_entry_s entry;

    modport ptw (
        output itlb_update,
        output dtlb_update,
        output entry
    );
    modport tlb (
        input itlb_update,
        input dtlb_update,
        input entry
    );
endinterface

module tlb #(
    parameter bit IS_ITLB = 1'b0
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          flush_i,
    input  wire logic [19:0]   lookup_vpn_i,
    output logic               hit_o,
    output mmu_pkg::tlb_entry_s entry_o,
    tlb_fill_if.tlb            fill
);

    mmu_pkg::tlb_entry_s                        entries [mmu_pkg::TLB_ENTRIES];
    logic [mmu_pkg::TLB_ENTRIES-1:0]            valid_q;
    logic [mmu_pkg::TLB_ENTRIES-1:0]            match;
    logic [$clog2(mmu_pkg::TLB_ENTRIES)-1:0]    ptr_q;
    logic                                       update;

    // Each instance listens to its own strobe from the walker
    assign update = IS_ITLB ? fill.itlb_update : fill.dtlb_update;

    // Superpages only compare VPN1
    always_comb begin
        for (int k = 0; k < mmu_pkg::TLB_ENTRIES; k++) begin
            if (entries[k].page_4m) begin
                match[k] = valid_q[k] && (entries[k].vpn[19:10] == lookup_vpn_i[19:10]);
            end else begin
                match[k] = valid_q[k] && (entries[k].vpn == lookup_vpn_i);
            end
        end
    end

    always_comb begin
        entry_o = '0;
        for (int k = 0; k < mmu_pkg::TLB_ENTRIES; k++) begin
            if (match[k]) begin
                entry_o = entries[k];
            end
        end
    end

    assign hit_o = |match;

    always_ff @(posedge clk) begin
        if (update) begin
            entries[ptr_q] <= fill.entry;
        end
    end

    // Round-robin replacement, flush drops every entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            ptr_q   <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (update) begin
            valid_q[ptr_q] <= fill.entry.valid;
            ptr_q          <= ptr_q + 1'b1;
        end
    end

    // Walker only fills after a miss, so lookups never match twice
    a_single_hit: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(match));

endmodule

`default_nettype wire

//--- verilog/mmu_ctrl.sv
`default_nettype none

interface walk_if;
    logic                      start;
    logic                      is_fetch;
    logic                      is_store;
    logic [mmu_pkg::VALEN-1:0] vaddr;
    logic [21:0]               satp_ppn;
    logic                      flush;
    logic                      busy;
    logic                      fill;
    logic                      page_err;

    modport ctrl (
        output start, is_fetch, is_store, vaddr, satp_ppn, flush,
        input  busy, fill, page_err
    );
    modport ptw (
        input  start, is_fetch, is_store, vaddr, satp_ppn, flush,
        output busy, fill, page_err
    );
endinterface

module mmu_ctrl (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        i_req_i,
    input  wire logic [mmu_pkg::VALEN-1:0]   i_vaddr_i,
    output logic                             i_done_o,
    output logic [mmu_pkg::PALEN-1:0]        i_paddr_o,
    output logic                             i_fault_o,
    input  wire logic                        d_req_i,
    input  wire logic                        d_store_i,
    input  wire logic [mmu_pkg::VALEN-1:0]   d_vaddr_i,
    output logic                             d_done_o,
    output logic [mmu_pkg::PALEN-1:0]        d_paddr_o,
    output logic                             d_fault_o,
    input  wire logic [21:0]                 satp_ppn_i,
    input  wire logic                        mxr_i,
    input  wire logic                        flush_i,
    input  wire logic                        itlb_hit_i,
    input  wire mmu_pkg::tlb_entry_s         itlb_entry_i,
    input  wire logic                        dtlb_hit_i,
    input  wire mmu_pkg::tlb_entry_s         dtlb_entry_i,
    output logic [19:0]                      i_vpn_o,
    output logic [19:0]                      d_vpn_o,
    walk_if.ctrl                             walk
);

    logic i_pend_q;
    logic d_pend_q;
    logic walk_free;
    logic d_need;
    logic d_start;
    logic i_start;
    logic i_hit_go;
    logic d_hit_go;

    function automatic logic perm_ok(input mmu_pkg::pte_flags_s f, input logic fetch,
                                     input logic store, input logic mxr);
        if (fetch) begin
            return f.x;
        end
        if (store) begin
            return f.w && f.d;
        end
        return f.r || (f.x && mxr);
    endfunction

    // Superpages keep VPN0 from the virtual address
    function automatic logic [mmu_pkg::PALEN-1:0] make_pa(input mmu_pkg::tlb_entry_s e,
                                                          input logic [mmu_pkg::VALEN-1:0] va);
        if (e.page_4m) begin
            return {e.ppn[19:10], va[21:0]};
        end
        return {e.ppn[19:0], va[11:0]};
    endfunction

    assign i_vpn_o = i_vaddr_i[31:12];
    assign d_vpn_o = d_vaddr_i[31:12];

    // A port in its done cycle is still holding req, so it is ignored there
    assign walk_free = !walk.busy && !i_pend_q && !d_pend_q && !flush_i;
    assign d_need    = d_req_i && !d_done_o && !d_pend_q && !dtlb_hit_i;
    assign d_start   = d_need && walk_free;
    assign i_start   = i_req_i && !i_done_o && !i_pend_q && !itlb_hit_i && !d_need && walk_free;
    assign i_hit_go  = i_req_i && !i_done_o && !i_pend_q && itlb_hit_i && !flush_i;
    assign d_hit_go  = d_req_i && !d_done_o && !d_pend_q && dtlb_hit_i && !flush_i;

    // Data side owns the walker whenever it needs it
    assign walk.start    = d_start || i_start;
    assign walk.is_fetch = !d_need;
    assign walk.is_store = d_need && d_store_i;
    assign walk.vaddr    = d_need ? d_vaddr_i : i_vaddr_i;
    assign walk.satp_ppn = satp_ppn_i;
    assign walk.flush    = flush_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            i_pend_q  <= 1'b0;
            d_pend_q  <= 1'b0;
            i_done_o  <= 1'b0;
            i_fault_o <= 1'b0;
            d_done_o  <= 1'b0;
            d_fault_o <= 1'b0;
        end else begin
            i_done_o  <= 1'b0;
            i_fault_o <= 1'b0;
            d_done_o  <= 1'b0;
            d_fault_o <= 1'b0;
            if (flush_i) begin
                // Aborted walks end silently
                i_pend_q <= 1'b0;
                d_pend_q <= 1'b0;
            end else begin
                if (i_start) begin
                    i_pend_q <= 1'b1;
                end else if (walk.fill || walk.page_err) begin
                    i_pend_q <= 1'b0;
                end
                if (d_start) begin
                    d_pend_q <= 1'b1;
                end else if (walk.fill || walk.page_err) begin
                    d_pend_q <= 1'b0;
                end
            end
            if (i_hit_go) begin
                i_done_o  <= 1'b1;
                i_fault_o <= !perm_ok(itlb_entry_i.flags, 1'b1, 1'b0, mxr_i);
            end else if (i_pend_q && walk.page_err && !flush_i) begin
                i_done_o  <= 1'b1;
                i_fault_o <= 1'b1;
            end
            if (d_hit_go) begin
                d_done_o  <= 1'b1;
                d_fault_o <= !perm_ok(dtlb_entry_i.flags, 1'b0, d_store_i, mxr_i);
            end else if (d_pend_q && walk.page_err && !flush_i) begin
                d_done_o  <= 1'b1;
                d_fault_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_hit_go) begin
            i_paddr_o <= make_pa(itlb_entry_i, i_vaddr_i);
        end
        if (d_hit_go) begin
            d_paddr_o <= make_pa(dtlb_entry_i, d_vaddr_i);
        end
    end

endmodule

`default_nettype wire

//--- verilog/ptw.sv
`default_nettype none

module ptw (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    walk_if.ptw                              walk,
    tlb_fill_if.ptw                          fill,
    output logic                             mem_req_o,
    output logic [mmu_pkg::PALEN-1:0]        mem_addr_o,
    input  wire logic                        mem_rvalid_i,
    input  wire logic [mmu_pkg::XLEN-1:0]    mem_rdata_i
);

    mmu_pkg::ptw_state_e        state_q;
    mmu_pkg::ptw_state_e        state_d;
    mmu_pkg::ptw_level_e        level_q;
    mmu_pkg::ptw_level_e        level_d;
    mmu_pkg::pte_u              pte;
    mmu_pkg::tlb_entry_s        fill_entry;
    logic [mmu_pkg::XLEN-1:0]   rdata_q;
    logic                       rvalid_q;
    logic [mmu_pkg::VALEN-1:0]  vaddr_q;
    logic [mmu_pkg::VALEN-1:0]  vaddr_d;
    logic [mmu_pkg::PALEN-1:0]  addr_q;
    logic [mmu_pkg::PALEN-1:0]  addr_d;
    logic                       req_q;
    logic                       req_d;
    logic                       fetch_q;
    logic                       fetch_d;
    logic                       g_q;
    logic                       g_d;
    logic                       do_fill;

    // Decisions are taken on the registered read data
    assign pte = rdata_q;

    always_comb begin
        state_d = state_q;
        level_d = level_q;
        vaddr_d = vaddr_q;
        addr_d  = addr_q;
        fetch_d = fetch_q;
        g_d     = g_q;
        req_d   = req_q && !mem_rvalid_i;
        do_fill = 1'b0;

        case (state_q)
            mmu_pkg::IDLE: begin
                if (walk.start) begin
                    // Physical addresses are 32 bits, upper satp PPN bits drop out
                    level_d = mmu_pkg::LEVEL_1;
                    g_d     = 1'b0;
                    fetch_d = walk.is_fetch;
                    vaddr_d = walk.vaddr;
                    addr_d  = {walk.satp_ppn[19:0], walk.vaddr[31:22], 2'b00};
                    req_d   = 1'b1;
                    state_d = mmu_pkg::PROCESS_PTE;
                end
            end

            mmu_pkg::PROCESS_PTE: begin
                if (rvalid_q) begin
                    if (!pte.leaf_view.flags.v ||
                        (pte.leaf_view.flags.w && !pte.leaf_view.flags.r)) begin
                        state_d = mmu_pkg::PAGE_ERR;
                    end else if (pte.leaf_view.flags.r || pte.leaf_view.flags.x) begin
                        // Leaf, superpage PPN0 has to be zero
                        if (!pte.leaf_view.flags.a ||
                            (level_q == mmu_pkg::LEVEL_1 && pte.leaf_view.ppn0 != '0)) begin
                            state_d = mmu_pkg::PAGE_ERR;
                        end else begin
                            do_fill = 1'b1;
                            state_d = mmu_pkg::IDLE;
                        end
                    end else if (level_q == mmu_pkg::LEVEL_1) begin
                        level_d = mmu_pkg::LEVEL_2;
                        g_d     = pte.table_view.flags.g;
                        addr_d  = {pte.table_view.ppn[19:0], vaddr_q[21:12], 2'b00};
                        req_d   = 1'b1;
                    end else begin
                        // Pointer found at the last level
                        state_d = mmu_pkg::PAGE_ERR;
                    end
                end
            end

            mmu_pkg::PAGE_ERR: begin
                state_d = mmu_pkg::IDLE;
            end

            mmu_pkg::WAIT_R_VALID: begin
                if (mem_rvalid_i) begin
                    state_d = mmu_pkg::IDLE;
                end
            end

            default: begin
                state_d = mmu_pkg::IDLE;
            end
        endcase

        // A read already issued must still be answered before going idle
        if (walk.flush) begin
            do_fill = 1'b0;
            if (req_q && !mem_rvalid_i) begin
                state_d = mmu_pkg::WAIT_R_VALID;
            end else begin
                state_d = mmu_pkg::IDLE;
                req_d   = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= mmu_pkg::IDLE;
            level_q  <= mmu_pkg::LEVEL_1;
            req_q    <= 1'b0;
            rvalid_q <= 1'b0;
            fetch_q  <= 1'b0;
            g_q      <= 1'b0;
        end else begin
            state_q  <= state_d;
            level_q  <= level_d;
            req_q    <= req_d;
            rvalid_q <= mem_rvalid_i;
            fetch_q  <= fetch_d;
            g_q      <= g_d;
        end
    end

    always_ff @(posedge clk) begin
        vaddr_q <= vaddr_d;
        addr_q  <= addr_d;
        rdata_q <= mem_rdata_i;
    end

    // Global bit from level 1 applies to the whole mapping
    always_comb begin
        fill_entry.valid   = 1'b1;
        fill_entry.vpn     = vaddr_q[31:12];
        fill_entry.ppn     = {pte.leaf_view.ppn1, pte.leaf_view.ppn0};
        fill_entry.page_4m = (level_q == mmu_pkg::LEVEL_1);
        fill_entry.flags   = pte.leaf_view.flags;
        fill_entry.flags.g = pte.leaf_view.flags.g | g_q;
    end

    assign fill.entry       = fill_entry;
    assign fill.itlb_update = do_fill && fetch_q;
    assign fill.dtlb_update = do_fill && !fetch_q;

    assign walk.busy     = (state_q != mmu_pkg::IDLE);
    assign walk.fill     = do_fill;
    assign walk.page_err = (state_q == mmu_pkg::PAGE_ERR) && !walk.flush;

    assign mem_req_o  = req_q;
    assign mem_addr_o = addr_q;

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(mem_req_o) |-> $past(mem_rvalid_i) || $past(walk.flush));

    a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
        !(walk.fill && walk.page_err));

endmodule

`default_nettype wire

//--- verilog/mmu_sv32_top.sv
`default_nettype none

module mmu_sv32_top (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        i_req_i,
    input  wire logic [mmu_pkg::VALEN-1:0]   i_vaddr_i,
    output logic                             i_done_o,
    output logic [mmu_pkg::PALEN-1:0]        i_paddr_o,
    output logic                             i_fault_o,
    input  wire logic                        d_req_i,
    input  wire logic                        d_store_i,
    input  wire logic [mmu_pkg::VALEN-1:0]   d_vaddr_i,
    output logic                             d_done_o,
    output logic [mmu_pkg::PALEN-1:0]        d_paddr_o,
    output logic                             d_fault_o,
    input  wire logic [21:0]                 satp_ppn_i,
    input  wire logic                        mxr_i,
    input  wire logic                        flush_i,
    output logic                             mem_req_o,
    output logic [mmu_pkg::PALEN-1:0]        mem_addr_o,
    input  wire logic                        mem_rvalid_i,
    input  wire logic [mmu_pkg::XLEN-1:0]    mem_rdata_i
);

    logic                itlb_hit;
    logic                dtlb_hit;
    mmu_pkg::tlb_entry_s itlb_entry;
    mmu_pkg::tlb_entry_s dtlb_entry;
    logic [19:0]         i_vpn;
    logic [19:0]         d_vpn;

    walk_if     u_walk ();
    tlb_fill_if u_fill ();

    mmu_ctrl i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_req_i      (i_req_i),
        .i_vaddr_i    (i_vaddr_i),
        .i_done_o     (i_done_o),
        .i_paddr_o    (i_paddr_o),
        .i_fault_o    (i_fault_o),
        .d_req_i      (d_req_i),
        .d_store_i    (d_store_i),
        .d_vaddr_i    (d_vaddr_i),
        .d_done_o     (d_done_o),
        .d_paddr_o    (d_paddr_o),
        .d_fault_o    (d_fault_o),
        .satp_ppn_i   (satp_ppn_i),
        .mxr_i        (mxr_i),
        .flush_i      (flush_i),
        .itlb_hit_i   (itlb_hit),
        .itlb_entry_i (itlb_entry),
        .dtlb_hit_i   (dtlb_hit),
        .dtlb_entry_i (dtlb_entry),
        .i_vpn_o      (i_vpn),
        .d_vpn_o      (d_vpn),
        .walk         (u_walk.ctrl)
    );

    ptw i_ptw (
        .clk          (clk),
        .rst_n        (rst_n),
        .walk         (u_walk.ptw),
        .fill         (u_fill.ptw),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    tlb #(.IS_ITLB(1'b1)) i_itlb (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .lookup_vpn_i (i_vpn),
        .hit_o        (itlb_hit),
        .entry_o      (itlb_entry),
        .fill         (u_fill.tlb)
    );

    tlb #(.IS_ITLB(1'b0)) i_dtlb (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .lookup_vpn_i (d_vpn),
        .hit_o        (dtlb_hit),
        .entry_o      (dtlb_entry),
        .fill         (u_fill.tlb)
    );

endmodule

`default_nettype wire

//--- bench/tb_mmu_sv32.sv
`default_nettype none

module tb_mmu_sv32;

    timeunit 1ns;
    timeprecision 100ps;

    // Words below REC_BASE mirror physical memory, records follow in triples
    localparam int IMAGE_WORDS = 4352;
    localparam int REC_BASE    = 4096;
    localparam int SLOW_DELAY  = 10;

    logic        clk;
    logic        rst_n;
    logic        i_req_i;
    logic [31:0] i_vaddr_i;
    logic        i_done_o;
    logic [31:0] i_paddr_o;
    logic        i_fault_o;
    logic        d_req_i;
    logic        d_store_i;
    logic [31:0] d_vaddr_i;
    logic        d_done_o;
    logic [31:0] d_paddr_o;
    logic        d_fault_o;
    logic [21:0] satp_ppn_i;
    logic        mxr_i;
    logic        flush_i;
    logic        mem_req_o;
    logic [31:0] mem_addr_o;
    logic        mem_rvalid_i;
    logic [31:0] mem_rdata_i;

    logic [31:0] image [IMAGE_WORDS];
    int          read_count;
    int          done_count;
    int          delay_left;
    bit          mem_busy;
    bit          slow_mem;
    int          cycle_count;
    int          cycle_limit;
    int          errors;
    int          passed;
    int          failed;

    mmu_sv32_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_req_i      (i_req_i),
        .i_vaddr_i    (i_vaddr_i),
        .i_done_o     (i_done_o),
        .i_paddr_o    (i_paddr_o),
        .i_fault_o    (i_fault_o),
        .d_req_i      (d_req_i),
        .d_store_i    (d_store_i),
        .d_vaddr_i    (d_vaddr_i),
        .d_done_o     (d_done_o),
        .d_paddr_o    (d_paddr_o),
        .d_fault_o    (d_fault_o),
        .satp_ppn_i   (satp_ppn_i),
        .mxr_i        (mxr_i),
        .flush_i      (flush_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Only the low 16 KiB hold page tables, anything above reads as V clear
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr[13:2]);
        if (addr[31:14] != '0) begin
            return {addr[31:2], 2'b00};
        end
        return image[idx];
    endfunction

    function automatic string describe_request(input int rec, input logic fetch,
                                               input logic store, input logic [31:0] vaddr);
        string kind;
        if (fetch) begin
            kind = "fetch";
        end else if (store) begin
            kind = "store";
        end else begin
            kind = "load";
        end
        return $sformatf("t%0d %s %08h", rec + 1, kind, vaddr);
    endfunction

    // Memory answers each read after 1 to 4 cycles, or slowly for the abort test
    initial begin : memory_model
        int unsigned seed_val;
        seed_val     = $urandom(99287);
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        mem_busy     = 1'b0;
        delay_left   = 0;
        read_count   = 0;
        forever begin
            tick();
            mem_rvalid_i = 1'b0;
            if (mem_req_o && rst_n) begin
                if (!mem_busy) begin
                    mem_busy   = 1'b1;
                    delay_left = slow_mem ? SLOW_DELAY : 1 + int'($urandom % 4);
                end
                delay_left--;
                if (delay_left == 0) begin
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i  = read_word(mem_addr_o);
                    read_count++;
                    mem_busy     = 1'b0;
                end
            end
        end
    end

    // Done outputs are stable at the falling edge
    initial begin : done_monitor
        done_count = 0;
        forever begin
            @(negedge clk);
            if (rst_n && i_done_o) begin
                done_count++;
            end
            if (rst_n && d_done_o) begin
                done_count++;
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: DUT gave no answer within %0d cycles", cycle_limit);
        $display("Test FAILED");
        $finish;
    end

    task automatic translate_request(input string name, input logic fetch, input logic store,
                                     input logic [31:0] vaddr, input logic exp_fault,
                                     input logic [31:0] exp_paddr);
        logic        seen;
        logic        got_fault;
        logic [31:0] got_paddr;
        seen = 1'b0;
        if (fetch) begin
            i_req_i   = 1'b1;
            i_vaddr_i = vaddr;
        end else begin
            d_req_i   = 1'b1;
            d_store_i = store;
            d_vaddr_i = vaddr;
        end
        while (!seen) begin
            @(negedge clk);
            seen = fetch ? i_done_o : d_done_o;
        end
        got_fault = fetch ? i_fault_o : d_fault_o;
        got_paddr = fetch ? i_paddr_o : d_paddr_o;
        tick();
        i_req_i   = 1'b0;
        d_req_i   = 1'b0;
        d_store_i = 1'b0;
        if (got_fault !== exp_fault) begin
            $display("** Error %s: fault expected %0b actual %0b", name, exp_fault, got_fault);
            errors++;
        end
        if (!exp_fault && got_paddr !== exp_paddr) begin
            $display("** Error %s: paddr expected %08h actual %08h", name, exp_paddr, got_paddr);
            errors++;
        end
    endtask

    // Flush while the first read is still outstanding, then let memory finish
    task automatic abort_walk(input logic [31:0] vaddr);
        logic seen;
        seen      = 1'b0;
        d_req_i   = 1'b1;
        d_store_i = 1'b0;
        d_vaddr_i = vaddr;
        while (!seen) begin
            @(negedge clk);
            seen = mem_req_o;
        end
        repeat (2) @(posedge clk);
        #1;
        flush_i = 1'b1;
        d_req_i = 1'b0;
        tick();
        flush_i = 1'b0;
        seen    = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = !mem_req_o;
        end
        repeat (4) @(negedge clk);
        tick();
    endtask

    task automatic check_record(input int rec);
        logic [31:0] ctrl;
        logic [31:0] vaddr;
        logic [31:0] exp_paddr;
        int          exp_reads;
        int          exp_dones;
        int          reads_start;
        int          dones_start;
        int          errors_start;
        string       name;
        ctrl         = image[REC_BASE + 3 * rec];
        vaddr        = image[REC_BASE + 3 * rec + 1];
        exp_paddr    = image[REC_BASE + 3 * rec + 2];
        exp_reads    = int'(ctrl[7:0]);
        exp_dones    = ctrl[8] ? 0 : 1;
        name         = describe_request(rec, ctrl[28], ctrl[24], vaddr);
        errors_start = errors;
        slow_mem     = ctrl[8];
        mxr_i        = ctrl[20];
        if (ctrl[16]) begin
            flush_i = 1'b1;
            tick();
            flush_i = 1'b0;
        end
        reads_start = read_count;
        dones_start = done_count;
        if (ctrl[8]) begin
            abort_walk(vaddr);
        end else begin
            translate_request(name, ctrl[28], ctrl[24], vaddr, ctrl[12], exp_paddr);
        end
        if (read_count - reads_start != exp_reads) begin
            $display("** Error %s: memory reads expected %0d actual %0d", name, exp_reads,
                     read_count - reads_start);
            errors++;
        end
        if (done_count - dones_start != exp_dones) begin
            $display("** Error %s: done pulses expected %0d actual %0d", name, exp_dones,
                     done_count - dones_start);
            errors++;
        end
        if (errors == errors_start) begin
            $display("PASS  %s", name);
            passed++;
        end else begin
            $display("FAIL  %s", name);
            failed++;
        end
    endtask

    initial begin : main
        int n_records;
        rst_n       = 1'b0;
        i_req_i     = 1'b0;
        i_vaddr_i   = '0;
        d_req_i     = 1'b0;
        d_store_i   = 1'b0;
        d_vaddr_i   = '0;
        satp_ppn_i  = 22'h000001;
        mxr_i       = 1'b0;
        flush_i     = 1'b0;
        slow_mem    = 1'b0;
        cycle_limit = 0;
        errors      = 0;
        passed      = 0;
        failed      = 0;
        for (int k = 0; k < IMAGE_WORDS; k++) begin
            image[k] = {k[15:0], 16'h0000};
        end
        $readmemh("bench/mmu_stimulus.txt", image);
        n_records = 0;
        while (REC_BASE + 3 * n_records + 2 < IMAGE_WORDS &&
               image[REC_BASE + 3 * n_records] != 32'hFFFF_FFFF) begin
            n_records++;
        end
        if (n_records == 0) begin
            $display("No request records found in the stimulus file");
            errors++;
        end
        cycle_limit = 60 * n_records + 20;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int rec = 0; rec < n_records; rec++) begin
            check_record(rec);
        end
        $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/mmu_stimulus.txt
// Memory words at their word index (byte address / 4), root table at satp PPN 1
// Records from @1000: ctrl vaddr paddr, ctrl digits port store mxr flush fault abort reads
@400
00000801 005000C7 005004C7 005000C6 006000C5 00000C01 00700087
@800
000040C7 0000444B 00004849 00000C01 00005043 00005447 000058C7
@C00
000080C7
@1000
00000002 00000ABC 00010ABC  // load through two levels
10000002 00001234 00011234  // fetch through two levels
00000001 00412345 01412345  // load from a 4 MiB superpage
00001001 00802000 00000000  // misaligned superpage
00000000 00000ABC 00010ABC  // TLB hit
00000000 00415678 01415678  // superpage hit
00010002 00000ABC 00010ABC  // walk again after flush
00001001 00C00000 00000000  // V clear
00001001 01000000 00000000  // W without R
00001002 00003000 00000000  // pointer at level 2
00001001 01800000 00000000  // A clear
10001002 00000100 00000000  // fetch from a page without X
01001002 00004040 00000000  // store to a read-only page
01001002 00005040 00000000  // store to a page with D clear
01000000 00000200 00010200  // store hit
00001002 00002010 00000000  // load from X-only page
00100000 00002010 00012010  // same load with MXR set
00000101 00006100 00000000  // flush during a slow walk
00000002 00006100 00016100  // walk after the abort
00000002 01400ABC 00020ABC  // second level-2 table
10000002 00001234 00011234  // fetch after the abort flush
FFFFFFFF 00000000 00000000

//--- all.f
verilog/mmu_pkg.sv
verilog/tlb.sv
verilog/mmu_ctrl.sv
verilog/ptw.sv
verilog/mmu_sv32_top.sv
bench/tb_mmu_sv32.sv

//--- Makefile
TOP = tb_mmu_sv32

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
